//--- Bender.yml
package:
  name: icache

sources:
  # Design
  - files:
      - src/icache_pkg.sv
      - src/icache_tag_array.sv
      - src/icache_data_array.sv
      - src/icache_controller.sv
      - src/icache_top.sv

  # Testbench and bound assertions
  - target: test
    files:
      - test/icache_properties.sv
      - test/icache_tb.sv

//--- src/icache_controller.sv
`timescale 1ns/1ps

module icache_controller #(
    parameter int INDEX_WIDTH = 3,
    localparam int tag_width = icache_pkg::addr_width - INDEX_WIDTH - icache_pkg::offset_width
) (
    input  logic                              clock,
    input  logic                              reset,

    // Fetch side, AXI4 read slave
    input  icache_pkg::ar_chan_t              fetch_ar,
    input  logic                              fetch_arvalid,
    output logic                              fetch_arready,
    output icache_pkg::r_chan_t               fetch_r,
    output logic                              fetch_rvalid,
    input  logic                              fetch_rready,

    // Memory side, AXI4 read master
    output icache_pkg::ar_chan_t              mem_ar,
    output logic                              mem_arvalid,
    input  logic                              mem_arready,
    input  icache_pkg::r_chan_t               mem_r,
    input  logic                              mem_rvalid,
    output logic                              mem_rready,

    // Array lookup
    output logic                              lookup_enable,
    output logic [INDEX_WIDTH-1:0]            lookup_index,
    input  logic [tag_width-1:0]              stored_tag,
    input  logic                              stored_valid,
    input  logic [icache_pkg::data_width-1:0] stored_word,

    // Array fill
    output logic                              fill_enable,
    output logic [INDEX_WIDTH-1:0]            fill_index,
    output logic [tag_width-1:0]              fill_tag,
    output logic [icache_pkg::data_width-1:0] fill_word
);

    typedef enum logic [1:0] {
        idle,
        lookup,
        miss,
        respond
    } state_t;

    state_t state;

    // Request address, held for the whole transaction
    logic [icache_pkg::addr_width-1:0] req_addr;
    logic [tag_width-1:0]              req_tag;
    logic [INDEX_WIDTH-1:0]            req_index;

    logic                hit;
    logic                ar_sent;
    logic                mem_r_hs;
    icache_pkg::r_chan_t hit_r;
    icache_pkg::r_chan_t resp_q;

    assign req_tag   = req_addr[icache_pkg::addr_width-1 -: tag_width];
    assign req_index = req_addr[icache_pkg::offset_width +: INDEX_WIDTH];

    // -------------------------------------------------------------------------
    // Lookup and hit detection
    // -------------------------------------------------------------------------

    assign fetch_arready = (state == idle);
    assign lookup_enable = fetch_arvalid & fetch_arready;
    assign lookup_index  = fetch_ar.addr[icache_pkg::offset_width +: INDEX_WIDTH];

    // Array outputs are valid in the lookup state only
    assign hit = stored_valid && (stored_tag == req_tag);

    always_comb begin
        hit_r.data = stored_word;
        hit_r.resp = icache_pkg::okay;
        hit_r.last = 1'b1;
    end

    always_ff @(posedge clock) begin
        if (lookup_enable) begin
            req_addr <= fetch_ar.addr;
        end
    end

    // -------------------------------------------------------------------------
    // Memory read
    // -------------------------------------------------------------------------

    // Address phase first, then wait for data within the miss state
    assign mem_ar.addr = req_addr;
    assign mem_arvalid = (state == miss) & ~ar_sent;
    assign mem_rready  = (state == miss) & ar_sent;
    assign mem_r_hs    = mem_rvalid & mem_rready;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            ar_sent <= 1'b0;
        end else if (mem_r_hs) begin
            ar_sent <= 1'b0;
        end else if (mem_arvalid && mem_arready) begin
            ar_sent <= 1'b1;
        end
    end

    // Only good data goes into the line
    assign fill_enable = mem_r_hs && (mem_r.resp == icache_pkg::okay);
    assign fill_index  = req_index;
    assign fill_tag    = req_tag;
    assign fill_word   = mem_r.data;

    // -------------------------------------------------------------------------
    // Fetch response
    // -------------------------------------------------------------------------

    // Hit answers straight from the arrays, everything else from resp_q
    assign fetch_rvalid = ((state == lookup) & hit) | (state == respond);
    assign fetch_r      = (state == lookup) ? hit_r : resp_q;

    always_ff @(posedge clock) begin
        if (state == lookup && hit) begin
            resp_q <= hit_r;
        end else if (mem_r_hs) begin
            resp_q <= mem_r;
        end
    end

    // State machine
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= idle;
        end else begin
            case (state)
                idle: begin
                    if (lookup_enable) begin
                        state <= lookup;
                    end
                end
                lookup: begin
                    if (!hit) begin
                        state <= miss;
                    end else if (fetch_rready) begin
                        state <= idle;
                    end else begin
                        state <= respond;
                    end
                end
                miss: begin
                    if (mem_r_hs) begin
                        state <= respond;
                    end
                end
                respond: begin
                    if (fetch_rready) begin
                        state <= idle;
                    end
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

endmodule

//--- src/icache_data_array.sv
`timescale 1ns/1ps

module icache_data_array #(
    parameter int INDEX_WIDTH = 3
) (
    input  logic                              clock,

    // Lookup port, word appears one cycle later
    input  logic                              lookup_enable,
    input  logic [INDEX_WIDTH-1:0]            lookup_index,
    output logic [icache_pkg::data_width-1:0] stored_word,

    // Fill port
    input  logic                              fill_enable,
    input  logic [INDEX_WIDTH-1:0]            fill_index,
    input  logic [icache_pkg::data_width-1:0] fill_word
);

    localparam int lines = 2 ** INDEX_WIDTH;

    // One instruction word per line
    logic [icache_pkg::data_width-1:0] words [lines];

    // Write port
    always_ff @(posedge clock) begin
        if (fill_enable) begin
            words[fill_index] <= fill_word;
        end
    end

    // Read port with output register, in step with the tag array
    always_ff @(posedge clock) begin
        if (lookup_enable) begin
            stored_word <= words[lookup_index];
        end
    end

endmodule

//--- src/icache_pkg.sv
package icache_pkg;

    // -------------------------------------------------------------------------
    // Widths
    // -------------------------------------------------------------------------

    // Fetch address and instruction word
    localparam int addr_width = 32;
    localparam int data_width = 32;

    // Byte offset inside one 4-byte word, the low address bits a line ignores
    localparam int offset_width = 2;

    // -------------------------------------------------------------------------
    // AXI4 read channels
    // -------------------------------------------------------------------------

    // Only the two codes this cache produces or forwards
    typedef enum logic [1:0] {
        okay   = 2'b00,
        slverr = 2'b10
    } resp_t;

    // Read address channel payload
    // Single beat, ID zero and word size, so only the address travels
    typedef struct packed {
        logic [addr_width-1:0] addr;
    } ar_chan_t;

    // Read data channel payload
    typedef struct packed {
        logic [data_width-1:0] data;
        resp_t                 resp;
        logic                  last;
    } r_chan_t;

endpackage

//--- src/icache_tag_array.sv
`timescale 1ns/1ps

module icache_tag_array #(
    parameter int INDEX_WIDTH = 3,
    localparam int tag_width = icache_pkg::addr_width - INDEX_WIDTH - icache_pkg::offset_width
) (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   flush,

    // Lookup port, result one cycle later
    input  logic                   lookup_enable,
    input  logic [INDEX_WIDTH-1:0] lookup_index,
    output logic [tag_width-1:0]   stored_tag,
    output logic                   stored_valid,

    // Fill port
    input  logic                   fill_enable,
    input  logic [INDEX_WIDTH-1:0] fill_index,
    input  logic [tag_width-1:0]   fill_tag
);

    localparam int lines = 2 ** INDEX_WIDTH;

    logic [lines-1:0]     valid_bits;
    logic [tag_width-1:0] tags [lines];

    // -------------------------------------------------------------------------
    // Valid bits
    // -------------------------------------------------------------------------

    // Flush wins over fill; fills only happen outside idle anyway
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            valid_bits <= '0;
        end else if (flush) begin
            valid_bits <= '0;
        end else if (fill_enable) begin
            valid_bits[fill_index] <= 1'b1;
        end
    end

    // Tag storage
    always_ff @(posedge clock) begin
        if (fill_enable) begin
            tags[fill_index] <= fill_tag;
        end
    end

    // -------------------------------------------------------------------------
    // Registered lookup
    // -------------------------------------------------------------------------

    // A lookup at the flush edge must already see the line as invalid
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            stored_valid <= 1'b0;
        end else if (lookup_enable) begin
            stored_valid <= valid_bits[lookup_index] & ~flush;
        end
    end

    always_ff @(posedge clock) begin
        if (lookup_enable) begin
            stored_tag <= tags[lookup_index];
        end
    end

endmodule

//--- src/icache_top.sv
`timescale 1ns/1ps

module icache_top #(
    parameter int INDEX_WIDTH = 3,
    localparam int tag_width = icache_pkg::addr_width - INDEX_WIDTH - icache_pkg::offset_width
) (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 flush,

    // Fetch side
    input  icache_pkg::ar_chan_t fetch_ar,
    input  logic                 fetch_arvalid,
    output logic                 fetch_arready,
    output icache_pkg::r_chan_t  fetch_r,
    output logic                 fetch_rvalid,
    input  logic                 fetch_rready,

    // Memory side
    output icache_pkg::ar_chan_t mem_ar,
    output logic                 mem_arvalid,
    input  logic                 mem_arready,
    input  icache_pkg::r_chan_t  mem_r,
    input  logic                 mem_rvalid,
    output logic                 mem_rready
);

    // -------------------------------------------------------------------------
    // Controller to array wiring
    // -------------------------------------------------------------------------

    logic                              lookup_enable;
    logic [INDEX_WIDTH-1:0]            lookup_index;
    logic [tag_width-1:0]              stored_tag;
    logic                              stored_valid;
    logic [icache_pkg::data_width-1:0] stored_word;

    logic                              fill_enable;
    logic [INDEX_WIDTH-1:0]            fill_index;
    logic [tag_width-1:0]              fill_tag;
    logic [icache_pkg::data_width-1:0] fill_word;

    icache_tag_array #(
        .INDEX_WIDTH (INDEX_WIDTH)
    ) i_icache_tag_array (
        .clock         (clock),
        .reset         (reset),
        .flush         (flush),
        .lookup_enable (lookup_enable),
        .lookup_index  (lookup_index),
        .stored_tag    (stored_tag),
        .stored_valid  (stored_valid),
        .fill_enable   (fill_enable),
        .fill_index    (fill_index),
        .fill_tag      (fill_tag)
    );

    icache_data_array #(
        .INDEX_WIDTH (INDEX_WIDTH)
    ) i_icache_data_array (
        .clock         (clock),
        .lookup_enable (lookup_enable),
        .lookup_index  (lookup_index),
        .stored_word   (stored_word),
        .fill_enable   (fill_enable),
        .fill_index    (fill_index),
        .fill_word     (fill_word)
    );

    icache_controller #(
        .INDEX_WIDTH (INDEX_WIDTH)
    ) i_icache_controller (
        .clock         (clock),
        .reset         (reset),
        .fetch_ar      (fetch_ar),
        .fetch_arvalid (fetch_arvalid),
        .fetch_arready (fetch_arready),
        .fetch_r       (fetch_r),
        .fetch_rvalid  (fetch_rvalid),
        .fetch_rready  (fetch_rready),
        .mem_ar        (mem_ar),
        .mem_arvalid   (mem_arvalid),
        .mem_arready   (mem_arready),
        .mem_r         (mem_r),
        .mem_rvalid    (mem_rvalid),
        .mem_rready    (mem_rready),
        .lookup_enable (lookup_enable),
        .lookup_index  (lookup_index),
        .stored_tag    (stored_tag),
        .stored_valid  (stored_valid),
        .stored_word   (stored_word),
        .fill_enable   (fill_enable),
        .fill_index    (fill_index),
        .fill_tag      (fill_tag),
        .fill_word     (fill_word)
    );

endmodule

//--- test/icache_properties.sv
`timescale 1ns/1ps

module icache_properties (
    input logic                 clock,
    input logic                 reset,
    input logic                 flush,
    input icache_pkg::ar_chan_t fetch_ar,
    input logic                 fetch_arvalid,
    input logic                 fetch_arready,
    input icache_pkg::r_chan_t  fetch_r,
    input logic                 fetch_rvalid,
    input logic                 fetch_rready,
    input icache_pkg::ar_chan_t mem_ar,
    input logic                 mem_arvalid,
    input logic                 mem_arready,
    input icache_pkg::r_chan_t  mem_r,
    input logic                 mem_rvalid,
    input logic                 mem_rready
);

    int unsigned failures = 0;

    logic                              ar_hs;
    logic                              mem_r_hs;
    logic [icache_pkg::addr_width-1:0] req_addr_q;
    logic                              all_invalid;
    logic                              mem_waiting;

    assign ar_hs    = fetch_arvalid & fetch_arready;
    assign mem_r_hs = mem_rvalid & mem_rready;

    // Address of the open request
    always_ff @(posedge clock) begin
        if (ar_hs) begin
            req_addr_q <= fetch_ar.addr;
        end
    end

    // Set by reset and flush, cleared by the first okay line fill after them
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            all_invalid <= 1'b1;
        end else if (flush) begin
            all_invalid <= 1'b1;
        end else if (mem_r_hs && mem_r.resp == icache_pkg::okay) begin
            all_invalid <= 1'b0;
        end
    end

    // Between the memory AR handshake and the memory R handshake
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            mem_waiting <= 1'b0;
        end else if (mem_r_hs) begin
            mem_waiting <= 1'b0;
        end else if (mem_arvalid && mem_arready) begin
            mem_waiting <= 1'b1;
        end
    end

    // -------------------------------------------------------------------------
    // Reset and lookup outcome
    // -------------------------------------------------------------------------

    assert property (@(posedge clock)
        reset || $past(reset) |-> !fetch_rvalid && !mem_arvalid && fetch_arready)
    else begin
        failures++;
        $error("outputs not in their reset state during or right after reset");
    end

    // Hit answers in cycle 1, a miss goes to memory in cycle 2
    assert property (@(posedge clock) disable iff (reset)
        $past(ar_hs, 2) |-> mem_arvalid == !$past(fetch_rvalid))
    else begin
        failures++;
        $error("hit or miss outcome does not match the lookup timing");
    end

    // No line can hit after reset or flush until a good fill
    assert property (@(posedge clock) disable iff (reset)
        $past(ar_hs) && $past(all_invalid || flush) |-> !fetch_rvalid)
    else begin
        failures++;
        $error("lookup hit although every line should be invalid");
    end

    assert property (@(posedge clock) disable iff (reset)
        mem_arvalid |-> mem_ar.addr == req_addr_q)
    else begin
        failures++;
        $error("memory read address differs from the fetch address");
    end

    // -------------------------------------------------------------------------
    // Handshake stability
    // -------------------------------------------------------------------------

    assert property (@(posedge clock) disable iff (reset)
        fetch_rvalid && !fetch_rready |=> fetch_rvalid && $stable(fetch_r))
    else begin
        failures++;
        $error("fetch response dropped or changed while fetch_rready was low");
    end

    assert property (@(posedge clock) disable iff (reset)
        fetch_rvalid && fetch_rready |=> fetch_arready)
    else begin
        failures++;
        $error("cache not ready for a new request after the fetch response");
    end

    assert property (@(posedge clock) disable iff (reset)
        mem_arvalid && !mem_arready |=> mem_arvalid && $stable(mem_ar))
    else begin
        failures++;
        $error("memory read request dropped or changed before mem_arready");
    end

    assert property (@(posedge clock) disable iff (reset)
        mem_rready |-> mem_waiting)
    else begin
        failures++;
        $error("mem_rready raised while no memory read was outstanding");
    end

    // -------------------------------------------------------------------------
    // Forwarding
    // -------------------------------------------------------------------------

    assert property (@(posedge clock) disable iff (reset)
        mem_r_hs |=> fetch_rvalid && fetch_r == $past(mem_r))
    else begin
        failures++;
        $error("memory response not forwarded to the fetch side one cycle later");
    end

endmodule

bind icache_top icache_properties i_icache_properties (.*);

//--- test/icache_tb.sv
`timescale 1ns/1ps

module icache_tb;

    localparam int index_width = 3;
    localparam int lines       = 2 ** index_width;
    localparam int tag_width   = icache_pkg::addr_width - index_width - icache_pkg::offset_width;

    // Nine directed requests before the random phase
    localparam int random_requests  = 40;
    localparam int total_requests   = 9 + random_requests;
    // Two stalls of up to 3 cycles, up to 3 held cycles and the FSM steps
    localparam int worst_miss_cycles = 16;
    localparam int cycle_limit      = total_requests * worst_miss_cycles + 100;

    logic                 clock = 1'b0;
    logic                 reset;
    logic                 flush;
    icache_pkg::ar_chan_t fetch_ar;
    logic                 fetch_arvalid;
    logic                 fetch_arready;
    icache_pkg::r_chan_t  fetch_r;
    logic                 fetch_rvalid;
    logic                 fetch_rready;
    icache_pkg::ar_chan_t mem_ar;
    logic                 mem_arvalid;
    logic                 mem_arready;
    icache_pkg::r_chan_t  mem_r;
    logic                 mem_rvalid;
    logic                 mem_rready;

    int          check_errors = 0;
    int          timeouts     = 0;
    int          cycle_count  = 0;
    int          mem_reads    = 0;
    logic [31:0] stim_state   = 32'he973b867;
    logic [31:0] stall_state  = 32'he973b867;

    // Expected cache contents, following the fill and flush rules
    logic                 ref_valid [lines];
    logic [tag_width-1:0] ref_tag [lines];

    always #4 clock = ~clock;

    icache_top #(
        .INDEX_WIDTH (index_width)
    ) i_icache_top (.*);

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Memory contents: word address scrambled, top nibble f gives slverr
    function automatic icache_pkg::r_chan_t memory_word(input logic [31:0] addr);
        icache_pkg::r_chan_t r;
        r.data = {addr[31:2], 2'b00} ^ 32'h5a5a5a5a;
        r.resp = (addr[31:28] == 4'hf) ? icache_pkg::slverr : icache_pkg::okay;
        r.last = 1'b1;
        return r;
    endfunction

    // -------------------------------------------------------------------------
    // Memory model with random stalls on both channels
    // -------------------------------------------------------------------------

    initial begin : memory_model
        logic [31:0] addr;
        mem_arready = 1'b0;
        mem_rvalid  = 1'b0;
        mem_r       = '0;
        forever begin
            @(negedge clock);
            if (mem_arvalid) begin
                stall_state = xorshift(stall_state);
                repeat (stall_state[1:0]) @(negedge clock);
                addr        = mem_ar.addr;
                mem_arready = 1'b1;
                @(negedge clock);
                mem_arready = 1'b0;
                mem_reads++;
                stall_state = xorshift(stall_state);
                repeat (stall_state[1:0]) @(negedge clock);
                mem_r      = memory_word(addr);
                mem_rvalid = 1'b1;
                while (!mem_rready) @(negedge clock);
                @(negedge clock);
                mem_rvalid = 1'b0;
            end
        end
    end

    // One fetch request, answer held back for hold cycles
    task automatic fetch_word(input logic [31:0] addr, input int hold);
        icache_pkg::r_chan_t    expected;
        icache_pkg::r_chan_t    got;
        logic [tag_width-1:0]   tag;
        logic [index_width-1:0] index;
        logic                   expect_hit;
        int                     reads_before;
        int                     latency;
        expected     = memory_word(addr);
        tag          = addr[31 -: tag_width];
        index        = addr[icache_pkg::offset_width +: index_width];
        expect_hit   = ref_valid[index] && ref_tag[index] == tag;
        reads_before = mem_reads;
        fetch_ar.addr = addr;
        fetch_arvalid = 1'b1;
        fetch_rready  = (hold == 0);
        while (!fetch_arready) @(negedge clock);
        @(negedge clock);
        fetch_arvalid = 1'b0;
        latency = 1;
        while (!fetch_rvalid) begin
            @(negedge clock);
            latency++;
        end
        repeat (hold) @(negedge clock);
        fetch_rready = 1'b1;
        got = fetch_r;
        @(negedge clock);
        fetch_rready = 1'b0;

        assert (got.data == expected.data) else begin
            check_errors++;
            $display("Error: fetch_r.data = %h, expected %h at address %h",
                     got.data, expected.data, addr);
        end
        assert (got.resp == expected.resp) else begin
            check_errors++;
            $display("Error: fetch_r.resp = %h, expected %h at address %h",
                     got.resp, expected.resp, addr);
        end
        assert (got.last == expected.last) else begin
            check_errors++;
            $display("Error: fetch_r.last = %h, expected %h at address %h",
                     got.last, expected.last, addr);
        end
        assert (mem_reads - reads_before == (expect_hit ? 0 : 1)) else begin
            check_errors++;
            $display("Error: memory reads = %h, expected %h at address %h",
                     mem_reads - reads_before, expect_hit ? 0 : 1, addr);
        end
        assert (!expect_hit || latency == 1) else begin
            check_errors++;
            $display("Error: fetch_rvalid latency = %h, expected 1 at address %h",
                     latency, addr);
        end
        if (!expect_hit && expected.resp == icache_pkg::okay) begin
            ref_valid[index] = 1'b1;
            ref_tag[index]   = tag;
        end
    endtask

    task automatic flush_cache();
        flush = 1'b1;
        @(negedge clock);
        flush = 1'b0;
        for (int i = 0; i < lines; i++) begin
            ref_valid[i] = 1'b0;
        end
    endtask

    task automatic finish_run();
        int total;
        total = check_errors + i_icache_top.i_icache_properties.failures;
        $display("Summary: %0d data errors, %0d assertion failures, %0d timeouts",
                 check_errors, i_icache_top.i_icache_properties.failures, timeouts);
        if (total == 0 && timeouts == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    endtask

    // -------------------------------------------------------------------------
    // Scenarios
    // -------------------------------------------------------------------------

    initial begin : stimulus
        logic [31:0] addr;
        int          hold;
        reset         = 1'b1;
        flush         = 1'b0;
        fetch_ar      = '0;
        fetch_arvalid = 1'b0;
        fetch_rready  = 1'b0;
        for (int i = 0; i < lines; i++) begin
            ref_valid[i] = 1'b0;
        end
        repeat (3) @(negedge clock);
        reset = 1'b0;
        @(negedge clock);

        // Cold miss, then hits, one of them under back-pressure
        fetch_word(32'h0000_1040, 0);
        fetch_word(32'h0000_1040, 0);
        fetch_word(32'h0000_1042, 3);
        // Same index, other tag replaces the line
        fetch_word(32'h0000_2040, 1);
        fetch_word(32'h0000_1040, 0);
        fetch_word(32'h0000_1040, 0);
        // Flush, then an error response that must not be cached
        flush_cache();
        fetch_word(32'h0000_1040, 0);
        fetch_word(32'hf000_0080, 2);
        fetch_word(32'hf000_0080, 0);

        // Small address pool so that hits and conflicts both occur
        for (int n = 0; n < random_requests; n++) begin
            stim_state = xorshift(stim_state);
            addr = {(stim_state[31:29] == 3'b111) ? 4'hf : 4'h0, 18'h0,
                    stim_state[9:8], 3'b000, stim_state[4:0]};
            hold = stim_state[13] ? int'(stim_state[12:11]) : 0;
            if (stim_state[20:17] == 4'h0) begin
                flush_cache();
            end
            fetch_word(addr, hold);
        end
        finish_run();
    end

    initial begin : watchdog
        while (cycle_count < cycle_limit) begin
            @(posedge clock);
            cycle_count++;
        end
        timeouts++;
        $display("Timeout: the run did not finish within %0d clock cycles", cycle_limit);
        finish_run();
    end

endmodule

//--- verilog.f
src/icache_pkg.sv
src/icache_tag_array.sv
src/icache_data_array.sv
src/icache_controller.sv
src/icache_top.sv
test/icache_properties.sv
test/icache_tb.sv
